/* logic/burst_split_pkg.sv */
// Burst splitter shared types

package burst_split_pkg;

  // ----------------------------------------
  // AXI field types
  // ----------------------------------------

  // Burst length, encoded as beats minus one
  typedef logic [7:0] len_t;

  // Log2 of the bytes in one transfer
  typedef logic [2:0] size_t;

  typedef logic [1:0] burst_t;

  typedef logic [1:0] resp_t;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ----------------------------------------
  // Beat bookkeeping
  // ----------------------------------------

  // Beats still owed by one burst, 1 up to 256
  typedef logic [8:0] cnt_t;

endpackage

/* logic/ax_if.sv */
// AXI address channel

`timescale 1ns/1ns

interface ax_if #(
  parameter int ADDR_WIDTH = 32,
  parameter int ID_WIDTH   = 4
) ();
  import burst_split_pkg::*;

  logic [ADDR_WIDTH-1:0] addr;
  logic [ID_WIDTH-1:0]   id;
  len_t                  len;
  size_t                 size;
  burst_t                burst;
  logic                  valid;
  logic                  ready;

  // Sender side drives the request, receiver answers with ready
  modport up_mp (
    output addr, id, len, size, burst, valid,
    input  ready
  );

  modport down_mp (
    input  addr, id, len, size, burst, valid,
    output ready
  );

endinterface

/* logic/beat_count_fifo.sv */
// Beat count FIFO

`timescale 1ns/1ns

module beat_count_fifo #(
  parameter int MAX_TXNS = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  push_i,
  input  burst_split_pkg::cnt_t push_cnt_i,
  output logic                  full_o,
  output logic                  head_valid_o,
  output logic                  head_last_o,
  input  logic                  beat_done_i
);
  import burst_split_pkg::*;

  localparam int PTR_W = (MAX_TXNS > 1) ? $clog2(MAX_TXNS) : 1;
  localparam int CNT_W = $clog2(MAX_TXNS + 1);

  cnt_t             mem [MAX_TXNS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] used;
  logic             do_push;
  logic             do_dec;
  logic             do_pop;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(MAX_TXNS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o       = (used == CNT_W'(MAX_TXNS));
  assign head_valid_o = (used != '0);
  assign head_last_o  = head_valid_o && (mem[rd_ptr] == cnt_t'(1));

  assign do_push = push_i && !full_o;
  assign do_dec  = beat_done_i && head_valid_o;
  // Head retires on its final beat
  assign do_pop  = do_dec && head_last_o;

  // ----------------------------------------
  // Pointers and fill level
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

  // ----------------------------------------
  // Count storage
  // ----------------------------------------
  // Write slot never equals the head while the head is live
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cnt_i;
    end
    if (do_dec && !do_pop) begin
      mem[rd_ptr] <= mem[rd_ptr] - 1'b1;
    end
  end

endmodule

/* logic/ax_splitter.sv */
// Address burst splitter

`timescale 1ns/1ns

module ax_splitter #(
  parameter int ADDR_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int MAX_TXNS   = 4
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  ax_if.down_mp up,
  ax_if.up_mp   down,
  output logic  head_valid_o,
  output logic  head_last_o,
  input  logic  beat_done_i
);
  import burst_split_pkg::*;

  typedef enum logic {ST_IDLE, ST_BUSY} state_t;

  state_t                state_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [ID_WIDTH-1:0]   id_q;
  len_t                  len_q;
  size_t                 size_q;
  burst_t                burst_q;

  logic [ADDR_WIDTH-1:0] cur_addr;
  logic [ID_WIDTH-1:0]   cur_id;
  len_t                  cur_len;
  size_t                 cur_size;
  burst_t                cur_burst;
  logic [ADDR_WIDTH-1:0] next_addr;
  cnt_t                  push_cnt;
  logic                  fifo_full;
  logic                  accept;
  logic                  fire;
  logic                  last_beat;

  beat_count_fifo #(
    .MAX_TXNS (MAX_TXNS)
  ) u_cnt_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (accept),
    .push_cnt_i   (push_cnt),
    .full_o       (fifo_full),
    .head_valid_o (head_valid_o),
    .head_last_o  (head_last_o),
    .beat_done_i  (beat_done_i)
  );

  assign push_cnt = {1'b0, up.len} + 9'd1;

  // ----------------------------------------
  // Current beat
  // ----------------------------------------
  // First beat comes straight from upstream, the rest from the held burst
  always_comb begin
    if (state_q == ST_IDLE) begin
      cur_addr  = up.addr;
      cur_id    = up.id;
      cur_len   = up.len;
      cur_size  = up.size;
      cur_burst = up.burst;
    end else begin
      cur_addr  = addr_q;
      cur_id    = id_q;
      cur_len   = len_q;
      cur_size  = size_q;
      cur_burst = burst_q;
    end
  end

  // FIXED and anything not INCR keep the address
  assign next_addr = (cur_burst == BURST_INCR) ?
                     cur_addr + (ADDR_WIDTH'(1) << cur_size) : cur_addr;

  assign up.ready   = (state_q == ST_IDLE) && !fifo_full;
  assign accept     = (state_q == ST_IDLE) && up.valid && !fifo_full;

  assign down.valid = (state_q == ST_BUSY) || accept;
  assign down.addr  = cur_addr;
  assign down.id    = cur_id;
  assign down.len   = '0;
  assign down.size  = cur_size;
  assign down.burst = cur_burst;

  assign fire      = down.valid && down.ready;
  assign last_beat = fire && (cur_len == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else if (accept && !last_beat) begin
      state_q <= ST_BUSY;
    end else if ((state_q == ST_BUSY) && last_beat) begin
      state_q <= ST_IDLE;
    end
  end

  // Remaining beats and the address of the next one
  always_ff @(posedge clk_i) begin
    if (accept || ((state_q == ST_BUSY) && fire)) begin
      id_q    <= cur_id;
      size_q  <= cur_size;
      burst_q <= cur_burst;
      if (fire) begin
        addr_q <= next_addr;
        len_q  <= cur_len - 1'b1;
      end else begin
        addr_q <= cur_addr;
        len_q  <= cur_len;
      end
    end
  end

endmodule

/* logic/b_merge.sv */
// Write response merge

`timescale 1ns/1ns

module b_merge (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   m_b_valid_i,
  input  burst_split_pkg::resp_t m_b_resp_i,
  output logic                   m_b_ready_o,
  output logic                   s_b_valid_o,
  output burst_split_pkg::resp_t s_b_resp_o,
  input  logic                   s_b_ready_i,
  input  logic                   head_valid_i,
  input  logic                   head_last_i,
  output logic                   beat_done_o
);
  import burst_split_pkg::*;

  logic absorb;
  logic err_q;
  logic m_fire;
  logic s_fire;

  // Inner beats of a burst never reach upstream
  assign absorb = head_valid_i && !head_last_i;

  // ----------------------------------------
  // Handshakes
  // ----------------------------------------
  assign m_b_ready_o = absorb ? 1'b1 : s_b_ready_i;
  assign s_b_valid_o = m_b_valid_i && !absorb;
  assign s_b_resp_o  = err_q ? RESP_SLVERR : m_b_resp_i;

  assign m_fire      = m_b_valid_i && m_b_ready_o;
  assign s_fire      = s_b_valid_o && s_b_ready_i;
  assign beat_done_o = m_fire;

  // ----------------------------------------
  // Sticky error of the current burst
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (s_fire) begin
      err_q <= 1'b0;
    end else if (m_fire && absorb && (m_b_resp_i == RESP_SLVERR)) begin
      err_q <= 1'b1;
    end
  end

endmodule

/* logic/burst_splitter_top.sv */
// AXI burst splitter

`timescale 1ns/1ns

module burst_splitter_top #(
  parameter int ADDR_WIDTH = 32,
  parameter int ID_WIDTH   = 4,
  parameter int DATA_WIDTH = 32,
  parameter int MAX_TXNS   = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Slave side
  input  logic [ADDR_WIDTH-1:0]   s_ar_addr_i,
  input  logic [ID_WIDTH-1:0]     s_ar_id_i,
  input  burst_split_pkg::len_t   s_ar_len_i,
  input  burst_split_pkg::size_t  s_ar_size_i,
  input  burst_split_pkg::burst_t s_ar_burst_i,
  input  logic                    s_ar_valid_i,
  output logic                    s_ar_ready_o,
  input  logic [ADDR_WIDTH-1:0]   s_aw_addr_i,
  input  logic [ID_WIDTH-1:0]     s_aw_id_i,
  input  burst_split_pkg::len_t   s_aw_len_i,
  input  burst_split_pkg::size_t  s_aw_size_i,
  input  burst_split_pkg::burst_t s_aw_burst_i,
  input  logic                    s_aw_valid_i,
  output logic                    s_aw_ready_o,
  input  logic [DATA_WIDTH-1:0]   s_w_data_i,
  input  logic [DATA_WIDTH/8-1:0] s_w_strb_i,
  input  logic                    s_w_valid_i,
  output logic                    s_w_ready_o,
  output logic [DATA_WIDTH-1:0]   s_r_data_o,
  output logic [ID_WIDTH-1:0]     s_r_id_o,
  output burst_split_pkg::resp_t  s_r_resp_o,
  output logic                    s_r_last_o,
  output logic                    s_r_valid_o,
  input  logic                    s_r_ready_i,
  output logic [ID_WIDTH-1:0]     s_b_id_o,
  output burst_split_pkg::resp_t  s_b_resp_o,
  output logic                    s_b_valid_o,
  input  logic                    s_b_ready_i,
  // Master side
  output logic [ADDR_WIDTH-1:0]   m_ar_addr_o,
  output logic [ID_WIDTH-1:0]     m_ar_id_o,
  output burst_split_pkg::len_t   m_ar_len_o,
  output burst_split_pkg::size_t  m_ar_size_o,
  output burst_split_pkg::burst_t m_ar_burst_o,
  output logic                    m_ar_valid_o,
  input  logic                    m_ar_ready_i,
  output logic [ADDR_WIDTH-1:0]   m_aw_addr_o,
  output logic [ID_WIDTH-1:0]     m_aw_id_o,
  output burst_split_pkg::len_t   m_aw_len_o,
  output burst_split_pkg::size_t  m_aw_size_o,
  output burst_split_pkg::burst_t m_aw_burst_o,
  output logic                    m_aw_valid_o,
  input  logic                    m_aw_ready_i,
  output logic [DATA_WIDTH-1:0]   m_w_data_o,
  output logic [DATA_WIDTH/8-1:0] m_w_strb_o,
  output logic                    m_w_last_o,
  output logic                    m_w_valid_o,
  input  logic                    m_w_ready_i,
  input  logic [DATA_WIDTH-1:0]   m_r_data_i,
  input  logic [ID_WIDTH-1:0]     m_r_id_i,
  input  burst_split_pkg::resp_t  m_r_resp_i,
  input  logic                    m_r_last_i,
  input  logic                    m_r_valid_i,
  output logic                    m_r_ready_o,
  input  logic [ID_WIDTH-1:0]     m_b_id_i,
  input  burst_split_pkg::resp_t  m_b_resp_i,
  input  logic                    m_b_valid_i,
  output logic                    m_b_ready_o
);

  logic r_head_valid;
  logic r_head_last;
  logic r_beat_done;
  logic b_head_valid;
  logic b_head_last;
  logic b_beat_done;

  ax_if #(.ADDR_WIDTH(ADDR_WIDTH), .ID_WIDTH(ID_WIDTH)) u_s_ar_if ();
  ax_if #(.ADDR_WIDTH(ADDR_WIDTH), .ID_WIDTH(ID_WIDTH)) u_s_aw_if ();
  ax_if #(.ADDR_WIDTH(ADDR_WIDTH), .ID_WIDTH(ID_WIDTH)) u_m_ar_if ();
  ax_if #(.ADDR_WIDTH(ADDR_WIDTH), .ID_WIDTH(ID_WIDTH)) u_m_aw_if ();

  // ----------------------------------------
  // Address channels onto interfaces
  // ----------------------------------------
  assign u_s_ar_if.addr  = s_ar_addr_i;
  assign u_s_ar_if.id    = s_ar_id_i;
  assign u_s_ar_if.len   = s_ar_len_i;
  assign u_s_ar_if.size  = s_ar_size_i;
  assign u_s_ar_if.burst = s_ar_burst_i;
  assign u_s_ar_if.valid = s_ar_valid_i;
  assign s_ar_ready_o    = u_s_ar_if.ready;

  assign u_s_aw_if.addr  = s_aw_addr_i;
  assign u_s_aw_if.id    = s_aw_id_i;
  assign u_s_aw_if.len   = s_aw_len_i;
  assign u_s_aw_if.size  = s_aw_size_i;
  assign u_s_aw_if.burst = s_aw_burst_i;
  assign u_s_aw_if.valid = s_aw_valid_i;
  assign s_aw_ready_o    = u_s_aw_if.ready;

  assign m_ar_addr_o     = u_m_ar_if.addr;
  assign m_ar_id_o       = u_m_ar_if.id;
  assign m_ar_len_o      = u_m_ar_if.len;
  assign m_ar_size_o     = u_m_ar_if.size;
  assign m_ar_burst_o    = u_m_ar_if.burst;
  assign m_ar_valid_o    = u_m_ar_if.valid;
  assign u_m_ar_if.ready = m_ar_ready_i;

  assign m_aw_addr_o     = u_m_aw_if.addr;
  assign m_aw_id_o       = u_m_aw_if.id;
  assign m_aw_len_o      = u_m_aw_if.len;
  assign m_aw_size_o     = u_m_aw_if.size;
  assign m_aw_burst_o    = u_m_aw_if.burst;
  assign m_aw_valid_o    = u_m_aw_if.valid;
  assign u_m_aw_if.ready = m_aw_ready_i;

  ax_splitter #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MAX_TXNS   (MAX_TXNS)
  ) u_ar_split (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .up           (u_s_ar_if.down_mp),
    .down         (u_m_ar_if.up_mp),
    .head_valid_o (r_head_valid),
    .head_last_o  (r_head_last),
    .beat_done_i  (r_beat_done)
  );

  ax_splitter #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MAX_TXNS   (MAX_TXNS)
  ) u_aw_split (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .up           (u_s_aw_if.down_mp),
    .down         (u_m_aw_if.up_mp),
    .head_valid_o (b_head_valid),
    .head_last_o  (b_head_last),
    .beat_done_i  (b_beat_done)
  );

  // ----------------------------------------
  // W path
  // ----------------------------------------
  // Every downstream write is a single beat
  assign m_w_data_o  = s_w_data_i;
  assign m_w_strb_o  = s_w_strb_i;
  assign m_w_last_o  = 1'b1;
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  // ----------------------------------------
  // R path
  // ----------------------------------------
  assign s_r_data_o  = m_r_data_i;
  assign s_r_id_o    = m_r_id_i;
  assign s_r_resp_o  = m_r_resp_i;
  assign s_r_valid_o = m_r_valid_i;
  assign m_r_ready_o = s_r_ready_i;
  // Without a tracked burst the downstream last is kept
  assign s_r_last_o  = r_head_valid ? r_head_last : m_r_last_i;
  assign r_beat_done = m_r_valid_i && s_r_ready_i;

  // ----------------------------------------
  // B path
  // ----------------------------------------
  assign s_b_id_o = m_b_id_i;

  b_merge u_b_merge (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_resp_i   (m_b_resp_i),
    .m_b_ready_o  (m_b_ready_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_resp_o   (s_b_resp_o),
    .s_b_ready_i  (s_b_ready_i),
    .head_valid_i (b_head_valid),
    .head_last_i  (b_head_last),
    .beat_done_o  (b_beat_done)
  );

endmodule

/* testbench/tb_axi_slave.sv */
// Single-beat AXI slave model

`timescale 1ns/1ns

module tb_axi_slave #(
  parameter int          ADDR_WIDTH = 32,
  parameter int          ID_WIDTH   = 4,
  parameter logic [31:0] SEED       = 32'd99706
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [ADDR_WIDTH-1:0]  ar_addr_i,
  input  logic [ID_WIDTH-1:0]    ar_id_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  logic [ADDR_WIDTH-1:0]  aw_addr_i,
  input  logic [ID_WIDTH-1:0]    aw_id_i,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  output logic [ADDR_WIDTH-1:0]  r_data_o,
  output logic [ID_WIDTH-1:0]    r_id_o,
  output burst_split_pkg::resp_t r_resp_o,
  output logic                   r_last_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output logic [ID_WIDTH-1:0]    b_id_o,
  output burst_split_pkg::resp_t b_resp_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i
);
  import burst_split_pkg::*;

  logic [31:0]                    rng;
  logic [ID_WIDTH+ADDR_WIDTH-1:0] r_q[$];
  logic [ID_WIDTH+ADDR_WIDTH-1:0] aw_q[$];
  logic [ID_WIDTH+1:0]            b_q[$];
  int                             w_cnt;

  function logic [14:0] next_rand();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng[30:16];
  endfunction

  // Error window is bit 4 of the beat address
  function resp_t resp_of(input logic [ADDR_WIDTH-1:0] addr);
    return addr[4] ? RESP_SLVERR : RESP_OKAY;
  endfunction

  initial begin
    rng        = SEED;
    w_cnt      = 0;
    ar_ready_o = 1'b0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    r_data_o   = '0;
    r_id_o     = '0;
    r_resp_o   = RESP_OKAY;
    r_last_o   = 1'b1;
    r_valid_o  = 1'b0;
    b_id_o     = '0;
    b_resp_o   = RESP_OKAY;
    b_valid_o  = 1'b0;
  end

  // ----------------------------------------
  // Handshakes seen on the rising edge
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_q.delete();
      aw_q.delete();
      b_q.delete();
      w_cnt = 0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        r_q.push_back({ar_id_i, ar_addr_i});
      end
      if (aw_valid_i && aw_ready_o) begin
        aw_q.push_back({aw_id_i, aw_addr_i});
      end
      if (w_valid_i && w_ready_o) begin
        w_cnt++;
      end
      if (r_valid_o && r_ready_i) begin
        void'(r_q.pop_front());
      end
      if (b_valid_o && b_ready_i) begin
        void'(b_q.pop_front());
      end
      // A write completes once both its address and its data are in
      while (aw_q.size() != 0 && w_cnt > 0) begin
        b_q.push_back({aw_q[0][ID_WIDTH+ADDR_WIDTH-1:ADDR_WIDTH],
                       resp_of(aw_q[0][ADDR_WIDTH-1:0])});
        void'(aw_q.pop_front());
        w_cnt--;
      end
    end
  end

  // ----------------------------------------
  // Outputs change on the falling edge
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      ar_ready_o = 1'b0;
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      r_valid_o  = 1'b0;
      b_valid_o  = 1'b0;
    end else begin
      ar_ready_o = (next_rand() % 4) != 0;
      aw_ready_o = (next_rand() % 4) != 0;
      w_ready_o  = (next_rand() % 4) != 0;
      r_valid_o  = (r_q.size() != 0);
      if (r_valid_o) begin
        {r_id_o, r_data_o} = r_q[0];
        r_resp_o = resp_of(r_data_o);
      end
      b_valid_o = (b_q.size() != 0);
      if (b_valid_o) begin
        {b_id_o, b_resp_o} = b_q[0];
      end
    end
  end

endmodule

/* testbench/tb_burst_splitter.sv */
// Burst splitter testbench

`timescale 1ns/1ns

module tb_burst_splitter;
  import burst_split_pkg::*;

  localparam int NUM_BURSTS = 60;

  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  id;
    len_t        len;
    size_t       size;
    burst_t      burst;
    logic [1:0]  gap;
  } burst_s;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic [1:0]  gap;
  } wbeat_s;

  // Expected single beats, in issue order
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  id;
    size_t       size;
    burst_t      burst;
  } ax_beat_s;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  id;
    resp_t       resp;
    logic        last;
  } r_beat_s;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] s_ar_addr_i, s_aw_addr_i, m_ar_addr_o, m_aw_addr_o;
  logic [3:0]  s_ar_id_i, s_aw_id_i, m_ar_id_o, m_aw_id_o;
  logic [3:0]  s_r_id_o, s_b_id_o, m_r_id_i, m_b_id_i;
  len_t        s_ar_len_i, s_aw_len_i, m_ar_len_o, m_aw_len_o;
  size_t       s_ar_size_i, s_aw_size_i, m_ar_size_o, m_aw_size_o;
  burst_t      s_ar_burst_i, s_aw_burst_i, m_ar_burst_o, m_aw_burst_o;
  resp_t       s_r_resp_o, s_b_resp_o, m_r_resp_i, m_b_resp_i;
  logic [31:0] s_w_data_i, m_w_data_o, s_r_data_o, m_r_data_i;
  logic [3:0]  s_w_strb_i, m_w_strb_o;
  logic        s_ar_valid_i, s_ar_ready_o, s_aw_valid_i, s_aw_ready_o;
  logic        s_w_valid_i, s_w_ready_o, s_r_last_o, s_r_valid_o, s_r_ready_i;
  logic        s_b_valid_o, s_b_ready_i, m_ar_valid_o, m_ar_ready_i;
  logic        m_aw_valid_o, m_aw_ready_i, m_w_last_o, m_w_valid_o, m_w_ready_i;
  logic        m_r_last_i, m_r_valid_i, m_r_ready_o, m_b_valid_i, m_b_ready_o;

  burst_s      rd_bursts[$];
  burst_s      wr_bursts[$];
  wbeat_s      w_beats[$];
  ax_beat_s    ar_exp[$];
  ax_beat_s    aw_exp[$];
  r_beat_s     r_exp[$];
  logic [5:0]  b_exp[$];
  logic [35:0] w_exp[$];
  logic [31:0] rng;
  int          cycle_cnt;
  int          total_beats;
  int          timeout_limit;
  bit          stim_started;
  bit          rd_done;
  bit          wr_done;
  bit          w_done;

  burst_splitter_top dut0 (.*);

  tb_axi_slave #(.SEED(32'd99706)) u_slave (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_addr_i  (m_ar_addr_o),
    .ar_id_i    (m_ar_id_o),
    .ar_valid_i (m_ar_valid_o),
    .ar_ready_o (m_ar_ready_i),
    .aw_addr_i  (m_aw_addr_o),
    .aw_id_i    (m_aw_id_o),
    .aw_valid_i (m_aw_valid_o),
    .aw_ready_o (m_aw_ready_i),
    .w_valid_i  (m_w_valid_o),
    .w_ready_o  (m_w_ready_i),
    .r_data_o   (m_r_data_i),
    .r_id_o     (m_r_id_i),
    .r_resp_o   (m_r_resp_i),
    .r_last_o   (m_r_last_i),
    .r_valid_o  (m_r_valid_i),
    .r_ready_i  (m_r_ready_o),
    .b_id_o     (m_b_id_i),
    .b_resp_o   (m_b_resp_i),
    .b_valid_o  (m_b_valid_i),
    .b_ready_i  (m_b_ready_o)
  );

  always #50 clk_i = ~clk_i;

  function logic [14:0] draw_rand();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng[30:16];
  endfunction

  function burst_s random_burst();
    burst_s b;
    b.addr  = {17'd0, draw_rand()};
    b.id    = 4'(draw_rand());
    b.len   = 8'(draw_rand() % 16);
    b.size  = 3'(draw_rand() % 3);
    b.burst = ((draw_rand() % 2) == 0) ? BURST_FIXED : BURST_INCR;
    b.gap   = 2'(draw_rand());
    return b;
  endfunction

  function logic [31:0] beat_addr(input logic [31:0] base, input size_t size,
                                  input burst_t burst, input int idx);
    if (burst == BURST_INCR) begin
      return base + (32'(idx) << size);
    end
    return base;
  endfunction

  function resp_t resp_for(input logic [31:0] addr);
    return addr[4] ? RESP_SLVERR : RESP_OKAY;
  endfunction

  function bit all_done();
    return rd_done && wr_done && w_done && ar_exp.size() == 0 && aw_exp.size() == 0 &&
           r_exp.size() == 0 && b_exp.size() == 0 && w_exp.size() == 0;
  endfunction

  task report_mismatch(input string test, input logic [63:0] exp_v, input logic [63:0] act_v);
    $display("Verification failed");
    $display("mismatch %s expected %0h actual %0h", test, exp_v, act_v);
    $fatal(1, "check failed");
  endtask

  task report_error(input string what);
    $display("Verification failed");
    $display("%s", what);
    $fatal(1, "run stopped");
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task check_beat(input string ch, input ax_beat_s e, input logic [31:0] addr,
                  input logic [3:0] id, input size_t size, input burst_t burst,
                  input len_t len);
    assert (len === 8'd0) else report_mismatch({ch, " len"}, 0, len);
    assert (addr === e.addr) else report_mismatch({ch, " addr"}, e.addr, addr);
    assert (id === e.id) else report_mismatch({ch, " id"}, e.id, id);
    assert (size === e.size) else report_mismatch({ch, " size"}, e.size, size);
    assert (burst === e.burst) else report_mismatch({ch, " burst"}, e.burst, burst);
  endtask

  task track_reads();
    logic [31:0] a;
    r_beat_s     re;
    if (s_ar_valid_i && s_ar_ready_o) begin
      for (int i = 0; i <= s_ar_len_i; i++) begin
        a = beat_addr(s_ar_addr_i, s_ar_size_i, s_ar_burst_i, i);
        ar_exp.push_back({a, s_ar_id_i, s_ar_size_i, s_ar_burst_i});
        r_exp.push_back({a, s_ar_id_i, resp_for(a), i == int'(s_ar_len_i)});
      end
    end
    if (m_ar_valid_o && m_ar_ready_i) begin
      if (ar_exp.size() == 0) report_error("read beat issued with no burst outstanding");
      check_beat("ar", ar_exp.pop_front(), m_ar_addr_o, m_ar_id_o, m_ar_size_o,
                 m_ar_burst_o, m_ar_len_o);
    end
    if (s_r_valid_o && s_r_ready_i) begin
      if (r_exp.size() == 0) report_error("read data returned with no beat outstanding");
      re = r_exp.pop_front();
      assert (s_r_data_o === re.data) else report_mismatch("r data", re.data, s_r_data_o);
      assert (s_r_id_o === re.id) else report_mismatch("r id", re.id, s_r_id_o);
      assert (s_r_resp_o === re.resp) else report_mismatch("r resp", re.resp, s_r_resp_o);
      assert (s_r_last_o === re.last) else report_mismatch("r last", re.last, s_r_last_o);
    end
  endtask

  task track_writes();
    logic [31:0] a;
    logic        err;
    logic [35:0] we;
    if (s_aw_valid_i && s_aw_ready_o) begin
      err = 1'b0;
      for (int i = 0; i <= s_aw_len_i; i++) begin
        a = beat_addr(s_aw_addr_i, s_aw_size_i, s_aw_burst_i, i);
        aw_exp.push_back({a, s_aw_id_i, s_aw_size_i, s_aw_burst_i});
        err = err | a[4];
      end
      b_exp.push_back({s_aw_id_i, err ? RESP_SLVERR : RESP_OKAY});
    end
    if (m_aw_valid_o && m_aw_ready_i) begin
      if (aw_exp.size() == 0) report_error("write beat issued with no burst outstanding");
      check_beat("aw", aw_exp.pop_front(), m_aw_addr_o, m_aw_id_o, m_aw_size_o,
                 m_aw_burst_o, m_aw_len_o);
    end
    if (s_w_valid_i && s_w_ready_o) w_exp.push_back({s_w_data_i, s_w_strb_i});
    if (m_w_valid_o && m_w_ready_i) begin
      if (w_exp.size() == 0) report_error("write data left with no beat sent upstream");
      we = w_exp.pop_front();
      assert (m_w_last_o === 1'b1) else report_mismatch("w last", 1, m_w_last_o);
      assert (m_w_data_o === we[35:4]) else report_mismatch("w data", we[35:4], m_w_data_o);
      assert (m_w_strb_o === we[3:0]) else report_mismatch("w strb", we[3:0], m_w_strb_o);
    end
    if (s_b_valid_o && s_b_ready_i) begin
      if (b_exp.size() == 0) report_error("write response with no burst outstanding");
      assert (s_b_id_o === b_exp[0][5:2]) else report_mismatch("b id", b_exp[0][5:2], s_b_id_o);
      assert (s_b_resp_o === b_exp[0][1:0])
        else report_mismatch("b resp", b_exp[0][1:0], s_b_resp_o);
      void'(b_exp.pop_front());
    end
  endtask

  // Single monitor keeps queue pushes ahead of same-cycle pops
  always @(posedge clk_i) begin
    if (cycle_cnt > 0 && !stim_started) begin
      assert ({m_ar_valid_o, m_aw_valid_o, m_w_valid_o, s_r_valid_o, s_b_valid_o} === 5'b0)
        else report_error("a valid output was high before any stimulus");
    end
    if (rst_n_i) begin
      track_reads();
      track_writes();
    end
    if (cycle_cnt > timeout_limit) report_error("run exceeded its cycle limit without finishing");
    cycle_cnt++;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (cycle_cnt > 4) begin
      s_r_ready_i = (draw_rand() % 4) != 0;
      s_b_ready_i = (draw_rand() % 4) != 0;
    end
  end

  task drive_reads();
    burst_s b;
    for (int i = 0; i < NUM_BURSTS; i++) begin
      b = rd_bursts[i];
      repeat (b.gap) @(negedge clk_i);
      {s_ar_addr_i, s_ar_id_i, s_ar_len_i, s_ar_size_i, s_ar_burst_i} = b[50:2];
      s_ar_valid_i = 1'b1;
      do @(posedge clk_i); while (s_ar_ready_o !== 1'b1);
      @(negedge clk_i);
      s_ar_valid_i = 1'b0;
    end
    rd_done = 1'b1;
  endtask

  task drive_writes();
    burst_s b;
    for (int i = 0; i < NUM_BURSTS; i++) begin
      b = wr_bursts[i];
      repeat (b.gap) @(negedge clk_i);
      {s_aw_addr_i, s_aw_id_i, s_aw_len_i, s_aw_size_i, s_aw_burst_i} = b[50:2];
      s_aw_valid_i = 1'b1;
      do @(posedge clk_i); while (s_aw_ready_o !== 1'b1);
      @(negedge clk_i);
      s_aw_valid_i = 1'b0;
    end
    wr_done = 1'b1;
  endtask

  task drive_wdata();
    wbeat_s w;
    for (int i = 0; i < w_beats.size(); i++) begin
      w = w_beats[i];
      repeat (w.gap) @(negedge clk_i);
      s_w_data_i  = w.data;
      s_w_strb_i  = w.strb;
      s_w_valid_i = 1'b1;
      do @(posedge clk_i); while (s_w_ready_o !== 1'b1);
      @(negedge clk_i);
      s_w_valid_i = 1'b0;
    end
    w_done = 1'b1;
  endtask

  initial begin
    rng          = 32'd99706;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    {s_ar_addr_i, s_ar_id_i, s_ar_len_i, s_ar_size_i, s_ar_burst_i, s_ar_valid_i} = '0;
    {s_aw_addr_i, s_aw_id_i, s_aw_len_i, s_aw_size_i, s_aw_burst_i, s_aw_valid_i} = '0;
    {s_w_data_i, s_w_strb_i, s_w_valid_i} = '0;
    s_r_ready_i  = 1'b0;
    s_b_ready_i  = 1'b0;
    cycle_cnt    = 0;
    total_beats  = 0;
    stim_started = 1'b0;
    rd_done      = 1'b0;
    wr_done      = 1'b0;
    w_done       = 1'b0;
    for (int i = 0; i < NUM_BURSTS; i++) begin
      rd_bursts.push_back(random_burst());
      wr_bursts.push_back(random_burst());
      total_beats += int'(rd_bursts[i].len) + int'(wr_bursts[i].len) + 2;
      for (int j = 0; j <= wr_bursts[i].len; j++) begin
        w_beats.push_back({draw_rand(), draw_rand(), 2'(draw_rand()), 4'(draw_rand()),
                           2'(draw_rand())});
      end
    end
    timeout_limit = 40 * total_beats + 1000;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    stim_started = 1'b1;
    fork
      drive_reads();
      drive_writes();
      drive_wdata();
    join
    while (!all_done()) @(negedge clk_i);
    // Extra beats after the last expected one would still be caught here
    repeat (10) @(posedge clk_i);
    $display("Verification passed");
    $finish;
  end

endmodule

/* project.f */
logic/burst_split_pkg.sv
logic/ax_if.sv
logic/beat_count_fifo.sv
logic/ax_splitter.sv
logic/b_merge.sv
logic/burst_splitter_top.sv
testbench/tb_axi_slave.sv
testbench/tb_burst_splitter.sv
